// File: Bender.yml
package:
  name: tex_cache

export_include_dirs:
  - src

sources:
  - files:
      - src/tex_cache_pkg.sv
      - src/tex_req_fifo.sv
      - src/tex_cache_tag.sv
      - src/tex_cache_ctrl.sv
      - src/tex_cache_mem.sv
      - src/tex_cache_regs.sv
      - src/tex_cache_top.sv
  - target: test
    files:
      - test/tex_cache_assertions.sv
      - test/tex_cache_tb.sv

// File: list.f
+incdir+src
src/tex_cache_pkg.sv
src/tex_req_fifo.sv
src/tex_cache_tag.sv
src/tex_cache_ctrl.sv
src/tex_cache_mem.sv
src/tex_cache_regs.sv
src/tex_cache_top.sv
test/tex_cache_assertions.sv
test/tex_cache_tb.sv

// File: src/tex_cache_cfg.svh
`ifndef TEX_CACHE_CFG_SVH
`define TEX_CACHE_CFG_SVH

// ----------------------------------------------------------------------
// texture cache geometry
// ----------------------------------------------------------------------

// width of each coordinate, x and y
`define TEX_ADDR_W 8

// log2 of the block edge, 4x4 pixel blocks
`define TEX_BLK_SIZE 2

// log2 of the number of cache lines
`define TEX_IDX_W 4

// pixel and request tag widths
`define TEX_PIX_W 16
`define TEX_USER_W 4

`endif

// File: src/tex_cache_ctrl.sv
`timescale 1ns/10ps
`include "tex_cache_cfg.svh"

module tex_cache_ctrl
	import tex_cache_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  tex_user_t    t_user,
	input  tex_idx_t     t_idx,
	input  tex_tag_t     t_tag,
	input  tex_pix_ofs_t t_ofs,
	input  tex_blk_t     t_blkx,
	input  tex_blk_t     t_blky,
	input  logic         t_hit,
	input  logic         t_strb,
	input  logic         t_valid,
	output logic         t_ready,
	output tex_addr_t    m_araddrx,
	output tex_addr_t    m_araddry,
	output logic         m_arvalid,
	input  logic         m_arready,
	input  tex_pix_t     m_rdata,
	input  logic         m_rvalid,
	input  logic         m_rlast,
	output logic         we,
	output tex_idx_t     w_idx,
	output tex_pix_ofs_t w_ofs,
	output tex_pix_t     w_data,
	output tex_user_t    c_user,
	output tex_idx_t     c_idx,
	output tex_pix_ofs_t c_ofs,
	output logic         c_blank,
	output logic         c_valid,
	input  logic         c_ready,
	output logic         fill_done,
	output tex_idx_t     fill_idx,
	output tex_tag_t     fill_tag,
	output logic         hit_pulse,
	output logic         miss_pulse
);

	tex_ctrl_state_t state;
	tex_user_t h_user;
	tex_idx_t h_idx;
	tex_pix_ofs_t h_ofs;
	tex_blk_t h_blkx;
	tex_blk_t h_blky;
	tex_tag_t h_tag;
	tex_pix_ofs_t fill_cnt;
	logic is_miss;
	logic accept;

	// misses are taken without waiting for the memory stage
	assign is_miss = t_valid && t_strb && !t_hit;
	assign t_ready = (state == IDLE) && (c_ready || is_miss);
	assign accept = t_valid && t_ready;
	assign hit_pulse = accept && t_hit;
	assign miss_pulse = accept && is_miss;

	// block origin of the held miss
	assign m_araddrx = {h_blkx, {`TEX_BLK_SIZE{1'b0}}};
	assign m_araddry = {h_blky, {`TEX_BLK_SIZE{1'b0}}};

	// line fill, one beat per write
	assign we = (state == FILL) && m_rvalid;
	assign w_idx = h_idx;
	assign w_ofs = fill_cnt;
	assign w_data = m_rdata;
	assign fill_done = we && m_rlast;
	assign fill_idx = h_idx;
	assign fill_tag = h_tag;

	always_comb begin
		if (state == ISSUE) begin
			c_user = h_user;
			c_idx = h_idx;
			c_ofs = h_ofs;
			c_blank = 1'b0;
			c_valid = 1'b1;
		end else begin
			c_user = t_user;
			c_idx = t_idx;
			c_ofs = t_ofs;
			c_blank = !t_strb;
			c_valid = (state == IDLE) && t_valid && !is_miss;
		end
	end

	// ----------------------------------------------------------------------
	// miss sequence
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			m_arvalid <= 1'b0;
			fill_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (accept && is_miss) begin
						state <= REQ;
						m_arvalid <= 1'b1;
					end
				end
				REQ: begin
					if (m_arready) begin
						m_arvalid <= 1'b0;
						fill_cnt <= '0;
						state <= FILL;
					end
				end
				FILL: begin
					if (m_rvalid) begin
						fill_cnt <= fill_cnt + 1'b1;
						if (m_rlast) begin
							state <= ISSUE;
						end
					end
				end
				ISSUE: begin
					if (c_ready) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// request waiting for its line
	always_ff @(posedge clk) begin
		if (accept && is_miss) begin
			h_user <= t_user;
			h_idx <= t_idx;
			h_ofs <= t_ofs;
			h_blkx <= t_blkx;
			h_blky <= t_blky;
			h_tag <= t_tag;
		end
	end

endmodule

// File: src/tex_cache_mem.sv
`timescale 1ns/10ps
`include "tex_cache_cfg.svh"

module tex_cache_mem
	import tex_cache_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         we,
	input  tex_idx_t     w_idx,
	input  tex_pix_ofs_t w_ofs,
	input  tex_pix_t     w_data,
	input  tex_user_t    c_user,
	input  tex_idx_t     c_idx,
	input  tex_pix_ofs_t c_ofs,
	input  logic         c_blank,
	input  logic         c_valid,
	output logic         c_ready,
	input  tex_pix_t     blank_value,
	output tex_user_t    r_user,
	output tex_pix_t     r_data,
	output logic         r_valid,
	input  logic         r_ready
);

	// one word per pixel, lines laid out back to back
	localparam int WORDS = 1 << (`TEX_IDX_W + 2 * `TEX_BLK_SIZE);

	tex_pix_t ram [WORDS];
	logic load;

	// ----------------------------------------------------------------------
	// line storage
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (we) begin
			ram[{w_idx, w_ofs}] <= w_data;
		end
	end

	// ----------------------------------------------------------------------
	// output register
	// ----------------------------------------------------------------------

	// a full register stalls the controller until the requester takes it
	assign c_ready = !r_valid || r_ready;
	assign load = c_valid && c_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			r_valid <= 1'b0;
		end else if (load) begin
			r_valid <= 1'b1;
		end else if (r_ready) begin
			r_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			r_user <= c_user;
			// out-of-texture requests skip the RAM word
			if (c_blank) begin
				r_data <= blank_value;
			end else begin
				r_data <= ram[{c_idx, c_ofs}];
			end
		end
	end

endmodule

// File: src/tex_cache_pkg.sv
`include "tex_cache_cfg.svh"

package tex_cache_pkg;

	// coordinates and their split into block and pixel parts
	typedef logic [`TEX_ADDR_W-1:0] tex_addr_t;
	typedef logic [`TEX_ADDR_W-`TEX_BLK_SIZE-1:0] tex_blk_t;
	typedef logic [2*`TEX_BLK_SIZE-1:0] tex_pix_ofs_t;

	// line index and tag, tag keeps what the index drops
	typedef logic [`TEX_IDX_W-1:0] tex_idx_t;
	typedef logic [2*(`TEX_ADDR_W-`TEX_BLK_SIZE)-`TEX_IDX_W-1:0] tex_tag_t;

	typedef logic [`TEX_PIX_W-1:0] tex_pix_t;
	typedef logic [`TEX_USER_W-1:0] tex_user_t;
	typedef logic [15:0] tex_cnt_t;

	// miss controller states
	typedef enum logic [1:0] {
		IDLE,
		REQ,
		FILL,
		ISSUE
	} tex_ctrl_state_t;

endpackage

// File: src/tex_cache_regs.sv
`timescale 1ns/10ps
`include "tex_cache_cfg.svh"

module tex_cache_regs
	import tex_cache_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	input  logic        clear_busy,
	input  logic        hit_pulse,
	input  logic        miss_pulse,
	output logic        clear_start,
	output tex_pix_t    blank_value
);

	localparam logic [3:0] ADDR_BLANK = 4'h0;
	localparam logic [3:0] ADDR_CTRL = 4'h4;
	localparam logic [3:0] ADDR_HITS = 4'h8;

	tex_pix_t blank_r;
	tex_cnt_t hit_cnt;
	tex_cnt_t miss_cnt;
	logic wr_en;

	// single-cycle access phase
	assign pready = 1'b1;
	assign wr_en = psel && penable && pwrite;
	assign clear_start = wr_en && (paddr == ADDR_CTRL) && pwdata[0];
	assign blank_value = blank_r;

	always_ff @(posedge clk) begin
		if (reset) begin
			blank_r <= '0;
			hit_cnt <= '0;
			miss_cnt <= '0;
		end else begin
			if (wr_en && (paddr == ADDR_BLANK)) begin
				blank_r <= pwdata[`TEX_PIX_W-1:0];
			end
			// counters wrap
			if (hit_pulse) begin
				hit_cnt <= hit_cnt + 1'b1;
			end
			if (miss_pulse) begin
				miss_cnt <= miss_cnt + 1'b1;
			end
		end
	end

	// read mux, MISSES sits at 0xC
	always_comb begin
		case (paddr)
			ADDR_BLANK: prdata = 32'(blank_r);
			ADDR_CTRL:  prdata = 32'(clear_busy);
			ADDR_HITS:  prdata = 32'(hit_cnt);
			default:    prdata = 32'(miss_cnt);
		endcase
	end

endmodule

// File: src/tex_cache_tag.sv
`timescale 1ns/10ps
`include "tex_cache_cfg.svh"

module tex_cache_tag
	import tex_cache_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  tex_user_t    q_user,
	input  tex_addr_t    q_addrx,
	input  tex_addr_t    q_addry,
	input  logic         q_strb,
	input  logic         q_valid,
	output logic         q_ready,
	input  logic         clear_start,
	output logic         clear_busy,
	input  logic         fill_done,
	input  tex_idx_t     fill_idx,
	input  tex_tag_t     fill_tag,
	output tex_user_t    t_user,
	output tex_idx_t     t_idx,
	output tex_tag_t     t_tag,
	output tex_pix_ofs_t t_ofs,
	output tex_blk_t     t_blkx,
	output tex_blk_t     t_blky,
	output logic         t_hit,
	output logic         t_strb,
	output logic         t_valid,
	input  logic         t_ready
);

	localparam int BLK_W = `TEX_ADDR_W - `TEX_BLK_SIZE;
	localparam int HALF_W = `TEX_IDX_W / 2;
	localparam int LINES = 1 << `TEX_IDX_W;

	tex_tag_t tag_arr [LINES];
	logic [LINES-1:0] vld;
	tex_idx_t clr_cnt;
	tex_blk_t q_blkx;
	tex_blk_t q_blky;
	tex_idx_t q_idx;
	tex_tag_t q_tag;
	logic q_hit;
	logic load;

	// ----------------------------------------------------------------------
	// address split and lookup
	// ----------------------------------------------------------------------
	assign q_blkx = q_addrx[`TEX_ADDR_W-1:`TEX_BLK_SIZE];
	assign q_blky = q_addry[`TEX_ADDR_W-1:`TEX_BLK_SIZE];
	assign q_idx = {q_blky[HALF_W-1:0], q_blkx[HALF_W-1:0]};
	assign q_tag = {q_blkx[BLK_W-1:HALF_W], q_blky[BLK_W-1:HALF_W]};

	always_comb begin
		q_hit = vld[q_idx] && (tag_arr[q_idx] == q_tag);
		// a fill landing this cycle wins over the stored entry
		if (fill_done && (fill_idx == q_idx)) begin
			q_hit = (fill_tag == q_tag);
		end
		q_hit = q_hit && q_strb;
	end

	// no lookups while the table is being cleared
	assign q_ready = !clear_busy && !clear_start && (!t_valid || t_ready);
	assign load = q_valid && q_ready;

	// ----------------------------------------------------------------------
	// valid bits and clear walk
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			t_valid <= 1'b0;
			clear_busy <= 1'b0;
			clr_cnt <= '0;
			vld <= '0;
		end else begin
			if (load) begin
				t_valid <= 1'b1;
			end else if (t_ready) begin
				t_valid <= 1'b0;
			end
			if (clear_start) begin
				clear_busy <= 1'b1;
				clr_cnt <= '0;
			end else if (clear_busy) begin
				vld[clr_cnt] <= 1'b0;
				clr_cnt <= clr_cnt + 1'b1;
				if (clr_cnt == tex_idx_t'(LINES - 1)) begin
					clear_busy <= 1'b0;
				end
			end
			if (fill_done) begin
				vld[fill_idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_done) begin
			tag_arr[fill_idx] <= fill_tag;
		end
		if (load) begin
			t_user <= q_user;
			t_idx <= q_idx;
			t_tag <= q_tag;
			t_ofs <= {q_addry[`TEX_BLK_SIZE-1:0], q_addrx[`TEX_BLK_SIZE-1:0]};
			t_blkx <= q_blkx;
			t_blky <= q_blky;
			t_hit <= q_hit;
			t_strb <= q_strb;
		end else if (t_valid && fill_done && (fill_idx == t_idx)) begin
			// held lookup goes stale when its line is refilled
			t_hit <= t_strb && (fill_tag == t_tag);
		end else if (clear_start) begin
			t_hit <= 1'b0;
		end
	end

endmodule

// File: src/tex_cache_top.sv
`timescale 1ns/10ps
`include "tex_cache_cfg.svh"

module tex_cache_top
	import tex_cache_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  tex_user_t   s_user,
	input  tex_addr_t   s_addrx,
	input  tex_addr_t   s_addry,
	input  logic        s_strb,
	input  logic        s_valid,
	output logic        s_ready,
	output tex_user_t   r_user,
	output tex_pix_t    r_data,
	output logic        r_valid,
	input  logic        r_ready,
	output tex_addr_t   m_araddrx,
	output tex_addr_t   m_araddry,
	output logic        m_arvalid,
	input  logic        m_arready,
	input  tex_pix_t    m_rdata,
	input  logic        m_rvalid,
	input  logic        m_rlast,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready
);

	// ----------------------------------------------------------------------
	// internal links
	// ----------------------------------------------------------------------
	tex_user_t q_user;
	tex_addr_t q_addrx;
	tex_addr_t q_addry;
	logic q_strb;
	logic q_valid;
	logic q_ready;

	tex_user_t t_user;
	tex_idx_t t_idx;
	tex_tag_t t_tag;
	tex_pix_ofs_t t_ofs;
	tex_blk_t t_blkx;
	tex_blk_t t_blky;
	logic t_hit;
	logic t_strb;
	logic t_valid;
	logic t_ready;

	logic we;
	tex_idx_t w_idx;
	tex_pix_ofs_t w_ofs;
	tex_pix_t w_data;
	tex_user_t c_user;
	tex_idx_t c_idx;
	tex_pix_ofs_t c_ofs;
	logic c_blank;
	logic c_valid;
	logic c_ready;

	// fill, clear and statistics
	logic fill_done;
	tex_idx_t fill_idx;
	tex_tag_t fill_tag;
	logic clear_start;
	logic clear_busy;
	logic hit_pulse;
	logic miss_pulse;
	tex_pix_t blank_value;

	tex_req_fifo #(
		.DEPTH(4)
	) u_fifo (
		.clk(clk),
		.reset(reset),
		.s_user(s_user),
		.s_addrx(s_addrx),
		.s_addry(s_addry),
		.s_strb(s_strb),
		.s_valid(s_valid),
		.s_ready(s_ready),
		.q_user(q_user),
		.q_addrx(q_addrx),
		.q_addry(q_addry),
		.q_strb(q_strb),
		.q_valid(q_valid),
		.q_ready(q_ready)
	);

	tex_cache_tag u_tag (
		.clk(clk),
		.reset(reset),
		.q_user(q_user),
		.q_addrx(q_addrx),
		.q_addry(q_addry),
		.q_strb(q_strb),
		.q_valid(q_valid),
		.q_ready(q_ready),
		.clear_start(clear_start),
		.clear_busy(clear_busy),
		.fill_done(fill_done),
		.fill_idx(fill_idx),
		.fill_tag(fill_tag),
		.t_user(t_user),
		.t_idx(t_idx),
		.t_tag(t_tag),
		.t_ofs(t_ofs),
		.t_blkx(t_blkx),
		.t_blky(t_blky),
		.t_hit(t_hit),
		.t_strb(t_strb),
		.t_valid(t_valid),
		.t_ready(t_ready)
	);

	tex_cache_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.t_user(t_user),
		.t_idx(t_idx),
		.t_tag(t_tag),
		.t_ofs(t_ofs),
		.t_blkx(t_blkx),
		.t_blky(t_blky),
		.t_hit(t_hit),
		.t_strb(t_strb),
		.t_valid(t_valid),
		.t_ready(t_ready),
		.m_araddrx(m_araddrx),
		.m_araddry(m_araddry),
		.m_arvalid(m_arvalid),
		.m_arready(m_arready),
		.m_rdata(m_rdata),
		.m_rvalid(m_rvalid),
		.m_rlast(m_rlast),
		.we(we),
		.w_idx(w_idx),
		.w_ofs(w_ofs),
		.w_data(w_data),
		.c_user(c_user),
		.c_idx(c_idx),
		.c_ofs(c_ofs),
		.c_blank(c_blank),
		.c_valid(c_valid),
		.c_ready(c_ready),
		.fill_done(fill_done),
		.fill_idx(fill_idx),
		.fill_tag(fill_tag),
		.hit_pulse(hit_pulse),
		.miss_pulse(miss_pulse)
	);

	tex_cache_mem u_mem (
		.clk(clk),
		.reset(reset),
		.we(we),
		.w_idx(w_idx),
		.w_ofs(w_ofs),
		.w_data(w_data),
		.c_user(c_user),
		.c_idx(c_idx),
		.c_ofs(c_ofs),
		.c_blank(c_blank),
		.c_valid(c_valid),
		.c_ready(c_ready),
		.blank_value(blank_value),
		.r_user(r_user),
		.r_data(r_data),
		.r_valid(r_valid),
		.r_ready(r_ready)
	);

	tex_cache_regs u_regs (
		.clk(clk),
		.reset(reset),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.clear_busy(clear_busy),
		.hit_pulse(hit_pulse),
		.miss_pulse(miss_pulse),
		.clear_start(clear_start),
		.blank_value(blank_value)
	);

endmodule

// File: src/tex_req_fifo.sv
`timescale 1ns/10ps
`include "tex_cache_cfg.svh"

module tex_req_fifo
	import tex_cache_pkg::*;
#(
	parameter int DEPTH = 4
) (
	input  logic      clk,
	input  logic      reset,
	input  tex_user_t s_user,
	input  tex_addr_t s_addrx,
	input  tex_addr_t s_addry,
	input  logic      s_strb,
	input  logic      s_valid,
	output logic      s_ready,
	output tex_user_t q_user,
	output tex_addr_t q_addrx,
	output tex_addr_t q_addry,
	output logic      q_strb,
	output logic      q_valid,
	input  logic      q_ready
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int ENT_W = `TEX_USER_W + 1 + 2 * `TEX_ADDR_W;

	logic [ENT_W-1:0] mem [DEPTH];
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic run;
	logic full;
	logic push;
	logic pop;

	// extra pointer bit tells full from empty
	assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
	assign s_ready = run && !full;
	assign q_valid = (wr_ptr != rd_ptr);
	assign push = s_valid && s_ready;
	assign pop = q_valid && q_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			run <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			run <= 1'b1;
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr[PTR_W-1:0]] <= {s_user, s_strb, s_addrx, s_addry};
		end
	end

	// head entry shows directly on the output
	assign {q_user, q_strb, q_addrx, q_addry} = mem[rd_ptr[PTR_W-1:0]];

endmodule

// File: test/tex_cache_assertions.sv
`timescale 1ns/10ps

module tex_cache_assertions
	import tex_cache_pkg::*;
(
	input logic      clk,
	input logic      reset,
	input logic      r_valid,
	input logic      r_ready,
	input tex_pix_t  r_data,
	input tex_user_t r_user,
	input logic      m_arvalid,
	input logic      m_arready,
	input tex_addr_t m_araddrx,
	input tex_addr_t m_araddry
);

	// number of failed assertions so far
	int fail_cnt = 0;

	// response held steady while the requester stalls
	assert property (@(posedge clk) disable iff (reset)
		r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_user))
	else begin
		fail_cnt++;
		$error("response changed under back-pressure");
	end

	// block read request waits for the memory
	assert property (@(posedge clk) disable iff (reset)
		m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddrx) && $stable(m_araddry))
	else begin
		fail_cnt++;
		$error("block read request dropped before m_arready");
	end

	assert property (@(posedge clk) reset |=> !r_valid && !m_arvalid)
	else begin
		fail_cnt++;
		$error("valid outputs not cleared by reset");
	end

endmodule

bind tex_cache_top tex_cache_assertions u_assert (
	.clk(clk),
	.reset(reset),
	.r_valid(r_valid),
	.r_ready(r_ready),
	.r_data(r_data),
	.r_user(r_user),
	.m_arvalid(m_arvalid),
	.m_arready(m_arready),
	.m_araddrx(m_araddrx),
	.m_araddry(m_araddry)
);

// File: test/tex_cache_tb.sv
`timescale 1ns/10ps
`include "tex_cache_cfg.svh"

module tex_cache_tb
	import tex_cache_pkg::*;
;

	localparam int CYCLE_LIMIT = 20000;
	localparam int LINES = 1 << `TEX_IDX_W;

	logic clk = 1'b0;
	logic reset;
	tex_user_t s_user;
	tex_addr_t s_addrx;
	tex_addr_t s_addry;
	logic s_strb;
	logic s_valid;
	logic s_ready;
	tex_user_t r_user;
	tex_pix_t r_data;
	logic r_valid;
	logic r_ready;
	tex_addr_t m_araddrx;
	tex_addr_t m_araddry;
	logic m_arvalid;
	logic m_arready;
	tex_pix_t m_rdata;
	logic m_rvalid;
	logic m_rlast;
	logic psel;
	logic penable;
	logic pwrite;
	logic [3:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;

	// reference model state
	tex_user_t exp_user [$];
	tex_pix_t exp_data [$];
	logic mirror_valid [LINES];
	tex_tag_t mirror_tag [LINES];
	int model_hits;
	int model_misses;
	tex_pix_t blank_model;

	logic [31:0] rng_state = 32'd48397;
	logic bp_on;
	int cycles;
	tex_user_t got_user;
	tex_pix_t got_data;
	tex_addr_t blk_x;
	tex_addr_t blk_y;
	int rd_delay;
	logic [31:0] rd_val;
	logic [31:0] rnd;
	tex_addr_t px [16];
	tex_addr_t py [16];
	int polls;

	tex_cache_top dut0 (.*);

	always #2 clk = ~clk;

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// texture content, {x, y}
	function automatic tex_pix_t pixel_at(input tex_addr_t x, input tex_addr_t y);
		return {x, y};
	endfunction

	function automatic tex_pix_t expected_pixel(input tex_addr_t x, input tex_addr_t y,
			input logic strb, input tex_pix_t blank);
		if (strb) begin
			return pixel_at(x, y);
		end
		return blank;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, expected);
			$display("test failed");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// direct-mapped lookup on the mirror, then queue the expected response
	task automatic model_request(input tex_user_t user, input tex_addr_t x,
			input tex_addr_t y, input logic strb);
		tex_blk_t bx;
		tex_blk_t by;
		tex_idx_t idx;
		tex_tag_t tag;
		bx = x[`TEX_ADDR_W-1:`TEX_BLK_SIZE];
		by = y[`TEX_ADDR_W-1:`TEX_BLK_SIZE];
		idx = {by[1:0], bx[1:0]};
		tag = {bx[5:2], by[5:2]};
		if (strb) begin
			if (mirror_valid[idx] && (mirror_tag[idx] == tag)) begin
				model_hits++;
			end else begin
				model_misses++;
				mirror_valid[idx] = 1'b1;
				mirror_tag[idx] = tag;
			end
		end
		exp_user.push_back(user);
		exp_data.push_back(expected_pixel(x, y, strb, blank_model));
	endtask

	task automatic model_clear();
		for (int i = 0; i < LINES; i++) begin
			mirror_valid[i] = 1'b0;
		end
	endtask

	// ----------------------------------------------------------------------
	// bus drivers, called and returning 1 ns after a rising edge
	// ----------------------------------------------------------------------
	task automatic send_req(input tex_user_t user, input tex_addr_t x,
			input tex_addr_t y, input logic strb);
		model_request(user, x, y, strb);
		s_valid = 1'b1;
		s_user = user;
		s_addrx = x;
		s_addry = y;
		s_strb = strb;
		while (!s_ready) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		s_valid = 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		while (!pready) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		while (!pready) begin
			@(posedge clk);
			#1;
		end
		data = prdata;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_drained();
		while (exp_data.size() != 0) begin
			@(posedge clk);
			#1;
		end
		repeat (2) @(posedge clk);
		#1;
	endtask

	task automatic check_counters();
		apb_read(4'h8, rd_val);
		check_value("HITS", rd_val, 32'(model_hits & 16'hffff));
		apb_read(4'hc, rd_val);
		check_value("MISSES", rd_val, 32'(model_misses & 16'hffff));
	endtask

	// ----------------------------------------------------------------------
	// texture memory model
	// ----------------------------------------------------------------------
	always begin
		@(posedge clk);
		#1;
		if (m_arvalid) begin
			blk_x = m_araddrx;
			blk_y = m_araddry;
			rd_delay = next_rand() % 4;
			repeat (rd_delay) begin
				@(posedge clk);
				#1;
			end
			m_arready = 1'b1;
			@(posedge clk);
			#1;
			m_arready = 1'b0;
			// raster order, x fastest
			for (int beat = 0; beat < 16; beat++) begin
				m_rvalid = 1'b1;
				m_rdata = pixel_at(blk_x + tex_addr_t'(beat % 4), blk_y + tex_addr_t'(beat / 4));
				m_rlast = (beat == 15);
				@(posedge clk);
				#1;
			end
			m_rvalid = 1'b0;
			m_rlast = 1'b0;
		end
	end

	// requester back-pressure
	always @(posedge clk) begin
		#1;
		r_ready = bp_on ? next_rand() % 2 : 1'b1;
	end

	// comparator, samples mid-cycle where the handshake is settled
	always @(negedge clk) begin
		if (!reset && r_valid && r_ready) begin
			if (exp_data.size() == 0) begin
				$display("a response arrived with no request outstanding");
				$display("test failed");
				$fatal(1, "unexpected response");
			end else begin
				got_user = exp_user.pop_front();
				got_data = exp_data.pop_front();
				check_value("r_user", r_user, got_user);
				check_value("r_data", r_data, got_data);
			end
		end
	end

	// bound protocol assertions
	always @(negedge clk) begin
		if (dut0.u_assert.fail_cnt != 0) begin
			$display("a protocol assertion on the DUT ports failed");
			$display("test failed");
			$fatal(1, "assertion failure");
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("the run took more than %0d cycles and was stopped", CYCLE_LIMIT);
			$display("test failed");
			$fatal(1, "timeout");
		end
	end

	// ----------------------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------------------
	initial begin
		reset = 1'b1;
		s_user = '0;
		s_addrx = '0;
		s_addry = '0;
		s_strb = 1'b0;
		s_valid = 1'b0;
		r_ready = 1'b0;
		m_arready = 1'b0;
		m_rdata = '0;
		m_rvalid = 1'b0;
		m_rlast = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		bp_on = 1'b0;
		cycles = 0;
		model_hits = 0;
		model_misses = 0;
		blank_model = '0;
		model_clear();
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;

		// registers out of reset
		check_counters();
		apb_read(4'h4, rd_val);
		check_value("CTRL", rd_val, 32'h0);
		apb_write(4'h0, 32'h0000_be5a);
		blank_model = 16'hbe5a;
		apb_read(4'h0, rd_val);
		check_value("BLANK", rd_val, 32'h0000_be5a);

		// one block per line, then the same coordinates again
		for (int i = 0; i < 16; i++) begin
			rnd = next_rand();
			px[i] = {4'h3, 2'(i), rnd[1:0]};
			py[i] = {4'h5, 2'(i >> 2), rnd[3:2]};
			send_req(4'(i), px[i], py[i], 1'b1);
		end
		for (int i = 0; i < 16; i++) begin
			send_req(4'(i), px[i], py[i], 1'b1);
		end
		wait_drained();
		apb_read(4'h8, rd_val);
		check_value("HITS", rd_val, 32'd16);
		apb_read(4'hc, rd_val);
		check_value("MISSES", rd_val, 32'd16);

		// outside the texture
		for (int i = 0; i < 8; i++) begin
			rnd = next_rand();
			send_req(rnd[3:0], rnd[15:8], rnd[23:16], 1'b0);
		end
		wait_drained();
		check_counters();

		// table clear
		apb_write(4'h4, 32'h1);
		model_clear();
		apb_read(4'h4, rd_val);
		check_value("CTRL", rd_val, 32'h1);
		polls = 0;
		while (rd_val[0]) begin
			polls++;
			if (polls > 40) begin
				$display("the clear busy flag never went low");
				$display("test failed");
				$fatal(1, "clear stuck");
			end else begin
				apb_read(4'h4, rd_val);
			end
		end
		for (int i = 0; i < 16; i++) begin
			send_req(4'(i), px[i], py[i], 1'b1);
		end
		wait_drained();
		check_counters();

		// random traffic with back-pressure
		bp_on = 1'b1;
		for (int i = 0; i < 400; i++) begin
			rnd = next_rand();
			send_req(rnd[3:0], {3'b000, rnd[8:4]}, {4'h0, rnd[15:12]}, rnd[18:16] != 3'd0);
			if (rnd[20]) begin
				@(posedge clk);
				#1;
			end
		end
		wait_drained();
		bp_on = 1'b0;
		check_counters();

		if (dut0.u_assert.fail_cnt != 0) begin
			$display("a protocol assertion on the DUT ports failed");
			$display("test failed");
			$fatal(1, "assertion failure");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule
